/* tb.f */
logic/roce_pkg.sv
logic/qp_tracker.sv
logic/payload_gen.sv
logic/payload_fifo.sv
logic/roce_msg_source.sv
verif/roce_msg_source_properties.sv
verif/tb_roce_msg_source.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_roce_msg_source -f tb.f --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* verif/tb_roce_msg_source.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_roce_msg_source;

  typedef struct packed {
    roce_pkg::xfer_cmd_t cmd;
    roce_pkg::pmtu_t     pmtu;
    logic [15:0]         stop_after;
    logic                back_pressure;
  } stim_row_t;

  logic                clk;
  logic                rst;
  logic                cmd_valid;
  roce_pkg::xfer_cmd_t cmd;
  roce_pkg::pmtu_t     pmtu;
  logic                stop;
  logic                hdr_valid;
  roce_pkg::msg_hdr_t  hdr;
  logic                hdr_ready;
  logic                pay_valid;
  roce_pkg::beat_t     pay;
  logic                pay_ready;
  logic                busy;

  stim_row_t          table_rows[$];
  roce_pkg::msg_hdr_t exp_hdr[$];
  roce_pkg::beat_t    exp_pay[$];
  int                 hdr_count;
  int                 watch_limit;
  logic               back_pressure;
  logic [15:0]        lfsr;

  roce_msg_source i_roce_msg_source (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .pmtu      (pmtu),
    .stop      (stop),
    .hdr_valid (hdr_valid),
    .hdr       (hdr),
    .hdr_ready (hdr_ready),
    .pay_valid (pay_valid),
    .pay       (pay),
    .pay_ready (pay_ready),
    .busy      (busy)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic longint unsigned pmtu_bytes(input roce_pkg::pmtu_t p);
    if (p inside {13'd256, 13'd512, 13'd1024, 13'd2048}) begin
      return longint'(p);
    end
    return 4096;
  endfunction

  function automatic int beats_in(input roce_pkg::len_t len);
    longint unsigned l;
    l = len;
    return int'((l + 7) / 8);
  endfunction

  function automatic int expected_msgs(input stim_row_t row);
    if (row.stop_after != 0 && row.stop_after < row.cmd.n_msgs) begin
      return int'(row.stop_after);
    end
    return int'(row.cmd.n_msgs);
  endfunction

  function automatic stim_row_t make_row(input roce_pkg::len_t len, input roce_pkg::qpn_t qpn,
                                         input roce_pkg::psn_t psn, input roce_pkg::rkey_t rkey,
                                         input roce_pkg::vaddr_t addr, input int n,
                                         input int mtu, input int stop_after, input logic bp);
    stim_row_t row;
    row.cmd.length   = len;
    row.cmd.rem_qpn  = qpn;
    row.cmd.rem_psn  = psn;
    row.cmd.r_key    = rkey;
    row.cmd.rem_addr = addr;
    row.cmd.n_msgs   = 16'(n);
    row.pmtu          = 13'(mtu);
    row.stop_after    = 16'(stop_after);
    row.back_pressure = bp;
    return row;
  endfunction

  function automatic int watchdog_cycles();
    int total;
    total = 0;
    foreach (table_rows[r]) begin
      total += expected_msgs(table_rows[r]) * (beats_in(table_rows[r].cmd.length) + 8);
    end
    return total * 4 + 500 + 50 * table_rows.size();
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH time %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic fail_run(input string what);
    $display("ERROR time %0t %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  // expected headers and beats straight from the message rules
  task automatic build_expected(input stim_row_t row);
    roce_pkg::msg_hdr_t h;
    roce_pkg::beat_t    b;
    roce_pkg::psn_t     psn;
    roce_pkg::vaddr_t   off;
    longint unsigned    len;
    longint unsigned    pkts;
    int                 nbeats;
    logic [31:0]        w;
    len    = row.cmd.length;
    pkts   = (len + pmtu_bytes(row.pmtu) - 1) / pmtu_bytes(row.pmtu);
    nbeats = beats_in(row.cmd.length);
    psn    = row.cmd.rem_psn;
    off    = '0;
    for (int m = 0; m < expected_msgs(row); m++) begin
      h.psn     = psn;
      h.dest_qp = row.cmd.rem_qpn;
      h.r_key   = row.cmd.r_key;
      h.vaddr   = row.cmd.rem_addr + off;
      h.length  = row.cmd.length;
      exp_hdr.push_back(h);
      for (int i = 0; i < nbeats; i++) begin
        w      = 32'(i * 8);
        b.data = {~w, w};
        b.last = (i == nbeats - 1);
        b.keep = '1;
        if (b.last && (len % 8) != 0) begin
          for (int k = 0; k < 8; k++) b.keep[k] = (k < int'(len % 8));
        end
        exp_pay.push_back(b);
      end
      psn = psn + 24'(pkts);
      off = off + len;
    end
  endtask

  task automatic run_row(input stim_row_t row);
    roce_pkg::xfer_cmd_t decoy;
    int                  hdr_base;
    build_expected(row);
    hdr_base      = hdr_count;
    back_pressure = row.back_pressure;
    pmtu          = row.pmtu;
    cmd           = row.cmd;
    cmd_valid     = 1'b1;
    @(posedge clk);
    #1;
    // second command while busy, must be dropped
    decoy          = row.cmd;
    decoy.rem_psn  = ~row.cmd.rem_psn;
    decoy.rem_addr = row.cmd.rem_addr ^ 64'hffff_0000_0000_0000;
    decoy.n_msgs   = row.cmd.n_msgs + 16'd3;
    cmd            = decoy;
    pmtu           = 13'd256;
    @(negedge clk);
    check_value("busy", busy, 1'b1);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    pmtu      = row.pmtu;
    if (row.stop_after != 0) begin
      wait (hdr_count - hdr_base >= int'(row.stop_after));
      @(posedge clk);
      #1;
      stop = 1'b1;
    end
    while (busy) @(negedge clk);
    check_value("headers still expected", 64'(exp_hdr.size()), 64'd0);
    @(posedge clk);
    #1;
    stop = 1'b0;
    while (exp_pay.size() != 0) @(negedge clk);
    repeat (3) begin
      @(negedge clk);
      check_value("hdr_valid", hdr_valid, 1'b0);
      check_value("pay_valid", pay_valid, 1'b0);
      check_value("busy", busy, 1'b0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic load_table();
    table_rows.push_back(make_row(300, 24'h11, 24'h000100, 32'h1000_0001,
                                  64'h0000_0001_0000_0000, 3, 256, 0, 1'b0));
    table_rows.push_back(make_row(13, 24'h12, 24'h00abcd, 32'h2000_0002,
                                  64'h0000_0000_8000_0000, 2, 512, 0, 1'b0));
    table_rows.push_back(make_row(1, 24'h13, 24'h123456, 32'h3000_0003,
                                  64'h0000_0000_0000_1000, 2, 1024, 0, 1'b0));
    table_rows.push_back(make_row(8, 24'h14, 24'h7fffff, 32'h4000_0004,
                                  64'h0000_0000_0000_2000, 2, 2048, 0, 1'b0));
    // psn wraps through zero
    table_rows.push_back(make_row(4100, 24'h15, 24'hfffffe, 32'h5000_0005,
                                  64'h0000_00ff_ffff_f000, 2, 4096, 0, 1'b0));
    table_rows.push_back(make_row(1024, 24'h16, 24'hffffff, 32'h6000_0006,
                                  64'h0000_0000_0010_0000, 2, 512, 0, 1'b0));
    table_rows.push_back(make_row(300, 24'h17, 24'h000200, 32'h7000_0007,
                                  64'h0000_0000_0020_0000, 2, 1000, 0, 1'b0));
    // several packets per message at 1024 and 2048
    table_rows.push_back(make_row(2500, 24'h1a, 24'h000500, 32'ha000_000a,
                                  64'h0000_0000_0050_0000, 2, 1024, 0, 1'b0));
    table_rows.push_back(make_row(4500, 24'h1b, 24'h000600, 32'hb000_000b,
                                  64'h0000_0000_0060_0000, 2, 2048, 0, 1'b0));
    table_rows.push_back(make_row(40, 24'h18, 24'h000300, 32'h8000_0008,
                                  64'h0000_0000_0030_0000, 5, 256, 2, 1'b0));
    // same traffic as rows 0 and 4, now with back-pressure
    table_rows.push_back(make_row(300, 24'h11, 24'h000100, 32'h1000_0001,
                                  64'h0000_0001_0000_0000, 3, 256, 0, 1'b1));
    table_rows.push_back(make_row(13, 24'h19, 24'h000400, 32'h9000_0009,
                                  64'h0000_0000_0040_0000, 4, 256, 3, 1'b1));
    table_rows.push_back(make_row(4100, 24'h15, 24'hfffffe, 32'h5000_0005,
                                  64'h0000_00ff_ffff_f000, 2, 4096, 0, 1'b1));
  endtask

  always @(posedge clk) begin
    #1;
    if (back_pressure) begin
      lfsr      = lfsr_next(lfsr);
      hdr_ready = lfsr[0];
      lfsr      = lfsr_next(lfsr);
      pay_ready = lfsr[0];
    end else begin
      hdr_ready = 1'b1;
      pay_ready = 1'b1;
    end
  end

  // transfers are taken at the negedge before the accepting edge
  always @(negedge clk) begin
    roce_pkg::msg_hdr_t eh;
    roce_pkg::beat_t    eb;
    if (!rst && hdr_valid && hdr_ready) begin
      if (exp_hdr.size() == 0) begin
        fail_run("header transfer seen when no header was expected");
      end else begin
        eh = exp_hdr.pop_front();
        check_value("hdr.psn", hdr.psn, eh.psn);
        check_value("hdr.dest_qp", hdr.dest_qp, eh.dest_qp);
        check_value("hdr.r_key", hdr.r_key, eh.r_key);
        check_value("hdr.vaddr", hdr.vaddr, eh.vaddr);
        check_value("hdr.length", hdr.length, eh.length);
        hdr_count++;
      end
    end
    if (!rst && pay_valid && pay_ready) begin
      if (exp_pay.size() == 0) begin
        fail_run("payload beat seen when no beat was expected");
      end else begin
        eb = exp_pay.pop_front();
        check_value("pay.data", pay.data, eb.data);
        check_value("pay.keep", pay.keep, eb.keep);
        check_value("pay.last", pay.last, eb.last);
      end
    end
  end

  initial begin
    wait (watch_limit > 0);
    repeat (watch_limit) @(posedge clk);
    $display("timeout after %0d clock cycles, the DUT stopped making progress", watch_limit);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    cmd_valid     = 1'b0;
    cmd           = '0;
    pmtu          = 13'd4096;
    stop          = 1'b0;
    hdr_ready     = 1'b1;
    pay_ready     = 1'b1;
    back_pressure = 1'b0;
    lfsr          = 16'd62;
    hdr_count     = 0;
    load_table();
    watch_limit = watchdog_cycles();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value("hdr_valid", hdr_valid, 1'b0);
      check_value("pay_valid", pay_valid, 1'b0);
      check_value("busy", busy, 1'b0);
    end
    @(posedge clk);
    #1;
    for (int r = 0; r < table_rows.size(); r++) begin
      run_row(table_rows[r]);
    end
    if (exp_hdr.size() != 0 || exp_pay.size() != 0) begin
      fail_run("expected transfers were left over at the end of the test");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/roce_msg_source_properties.sv */
`default_nettype none
`timescale 1ns/100ps

module roce_msg_source_properties (
  input logic               clk,
  input logic               rst,
  input logic               hdr_valid,
  input roce_pkg::msg_hdr_t hdr,
  input logic               hdr_ready,
  input logic               pay_valid,
  input roce_pkg::beat_t    pay,
  input logic               pay_ready,
  input logic               gen_valid,
  input logic               gen_ready
);

  // fifo fill level seen from its two handshakes
  logic [$clog2(roce_pkg::fifo_depth+1)-1:0] occupancy;
  logic wr;
  logic rd;

  assign wr = gen_valid && gen_ready;
  assign rd = pay_valid && pay_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      occupancy <= '0;
    end else if (wr && !rd) begin
      occupancy <= occupancy + 1'b1;
    end else if (rd && !wr) begin
      occupancy <= occupancy - 1'b1;
    end
  end

  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr))
    else $error("header stream changed while stalled");

  pay_hold: assert property (@(posedge clk) disable iff (rst)
    pay_valid && !pay_ready |=> pay_valid && $stable(pay))
    else $error("payload stream changed while stalled");

  reset_quiet: assert property (@(posedge clk)
    rst |=> !hdr_valid && !pay_valid)
    else $error("valid raised right after reset");

  no_empty_read: assert property (@(posedge clk) disable iff (rst)
    pay_valid |-> occupancy != '0)
    else $error("payload valid while the fifo is empty");

endmodule

bind roce_msg_source roce_msg_source_properties i_roce_msg_source_properties (
  .clk       (clk),
  .rst       (rst),
  .hdr_valid (hdr_valid),
  .hdr       (hdr),
  .hdr_ready (hdr_ready),
  .pay_valid (pay_valid),
  .pay       (pay),
  .pay_ready (pay_ready),
  .gen_valid (gen_valid),
  .gen_ready (gen_ready)
);

`default_nettype wire

/* logic/roce_msg_source.sv */
`default_nettype none
`timescale 1ns/100ps

module roce_msg_source (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  roce_pkg::xfer_cmd_t  cmd,
  input  roce_pkg::pmtu_t      pmtu,
  input  logic                 stop,
  output logic                 hdr_valid,
  output roce_pkg::msg_hdr_t   hdr,
  input  logic                 hdr_ready,
  output logic                 pay_valid,
  output roce_pkg::beat_t      pay,
  input  logic                 pay_ready,
  output logic                 busy
);

  // tracker to generator
  logic           msg_start;
  roce_pkg::len_t msg_len;
  logic           msg_done;

  // generator to buffer
  logic            gen_valid;
  roce_pkg::beat_t gen_beat;
  logic            gen_ready;

  qp_tracker i_qp_tracker (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .pmtu      (pmtu),
    .stop      (stop),
    .msg_done  (msg_done),
    .hdr_valid (hdr_valid),
    .hdr       (hdr),
    .msg_start (msg_start),
    .msg_len   (msg_len),
    .busy      (busy),
    .hdr_ready (hdr_ready)
  );

  payload_gen i_payload_gen (
    .clk       (clk),
    .rst       (rst),
    .msg_start (msg_start),
    .msg_len   (msg_len),
    .out_valid (gen_valid),
    .out       (gen_beat),
    .out_ready (gen_ready),
    .msg_done  (msg_done)
  );

  payload_fifo #(
    .depth (roce_pkg::fifo_depth)
  ) i_payload_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (gen_valid),
    .in        (gen_beat),
    .in_ready  (gen_ready),
    .out_valid (pay_valid),
    .out       (pay),
    .out_ready (pay_ready)
  );

endmodule

`default_nettype wire

/* logic/payload_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module payload_fifo #(
  parameter int depth = roce_pkg::fifo_depth
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  roce_pkg::beat_t  in,
  output logic             in_ready,
  output logic             out_valid,
  output roce_pkg::beat_t  out,
  input  logic             out_ready
);

  roce_pkg::beat_t mem [depth];

  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic [$clog2(depth+1)-1:0] count;

  logic wr_en;
  logic rd_en;

  assign in_ready  = (count != depth[$clog2(depth+1)-1:0]);
  assign out_valid = (count != '0);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves occupancy unchanged
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in;
    end
  end

  assign out = mem[rd_ptr];

endmodule

`default_nettype wire

/* logic/payload_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module payload_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 msg_start,
  input  roce_pkg::len_t       msg_len,
  output logic                 out_valid,
  output roce_pkg::beat_t      out,
  input  logic                 out_ready,
  output logic                 msg_done
);

  logic           active;
  roce_pkg::len_t w;
  roce_pkg::len_t len;

  // one extra bit so w + 8 cannot wrap
  logic [32:0] w_end;
  logic        beat_fire;

  // byte enables for a partial last beat, 0 means a full beat
  function automatic roce_pkg::beat_keep_t tail_keep(input logic [2:0] n);
    roce_pkg::beat_keep_t k;
    begin
      if (n == 3'd0) begin
        k = '1;
      end else begin
        k = roce_pkg::beat_keep_t'((9'd1 << n) - 9'd1);
      end
      return k;
    end
  endfunction

  assign w_end     = {1'b0, w} + 33'(roce_pkg::data_bytes);
  assign beat_fire = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else if (msg_start) begin
      active <= 1'b1;
    end else if (beat_fire && out.last) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (msg_start) begin
      w   <= '0;
      len <= msg_len;
    end else if (beat_fire) begin
      w <= w + roce_pkg::len_t'(roce_pkg::data_bytes);
    end
  end

  // counter pattern, low word w and high word its inverse
  assign out.data = {~w, w};
  assign out.last = (w_end >= {1'b0, len});
  assign out.keep = out.last ? tail_keep(len[2:0]) : '1;

  assign out_valid = active;
  assign msg_done  = beat_fire && out.last;

endmodule

`default_nettype wire

/* logic/qp_tracker.sv */
`default_nettype none
`timescale 1ns/100ps

module qp_tracker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  roce_pkg::xfer_cmd_t  cmd,
  input  roce_pkg::pmtu_t      pmtu,
  input  logic                 stop,
  input  logic                 msg_done,
  output logic                 hdr_valid,
  output roce_pkg::msg_hdr_t   hdr,
  output logic                 msg_start,
  output roce_pkg::len_t       msg_len,
  output logic                 busy,
  input  logic                 hdr_ready
);

  roce_pkg::tracker_state_t state;

  // queue pair context
  roce_pkg::xfer_cmd_t   ctx;
  roce_pkg::psn_t        psn;
  roce_pkg::vaddr_t      offset;
  roce_pkg::msg_count_t  sent;
  roce_pkg::pmtu_shift_t pmtu_shift;
  roce_pkg::pmtu_mask_t  pmtu_mask;

  roce_pkg::pmtu_shift_t shift_d;
  roce_pkg::pmtu_mask_t  mask_d;
  roce_pkg::len_t        pkt_count;

  logic accept;
  logic hdr_fire;
  logic last_msg;

  assign accept   = cmd_valid && (state == roce_pkg::idle);
  assign hdr_fire = hdr_valid && hdr_ready;
  assign last_msg = stop || (sent >= ctx.n_msgs);

  // unknown sizes fall back to 4096
  always_comb begin
    case (pmtu)
      13'd256: begin
        shift_d = 4'd8;
        mask_d  = 12'h0ff;
      end
      13'd512: begin
        shift_d = 4'd9;
        mask_d  = 12'h1ff;
      end
      13'd1024: begin
        shift_d = 4'd10;
        mask_d  = 12'h3ff;
      end
      13'd2048: begin
        shift_d = 4'd11;
        mask_d  = 12'h7ff;
      end
      default: begin
        shift_d = 4'd12;
        mask_d  = 12'hfff;
      end
    endcase
  end

  // packets per message, rounded up
  assign pkt_count = (ctx.length >> pmtu_shift)
                   + roce_pkg::len_t'(|(ctx.length[11:0] & pmtu_mask));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= roce_pkg::idle;
      msg_start <= 1'b0;
      sent      <= '0;
    end else begin
      msg_start <= hdr_fire;
      if (accept) begin
        sent <= '0;
      end else if (hdr_fire) begin
        sent <= sent + 1'b1;
      end
      case (state)
        roce_pkg::idle: begin
          if (cmd_valid) state <= roce_pkg::issue_hdr;
        end
        roce_pkg::issue_hdr: begin
          if (hdr_ready) state <= roce_pkg::wait_payload;
        end
        roce_pkg::wait_payload: begin
          if (msg_done) state <= last_msg ? roce_pkg::idle : roce_pkg::issue_hdr;
        end
        default: state <= roce_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ctx        <= cmd;
      psn        <= cmd.rem_psn;
      offset     <= '0;
      pmtu_shift <= shift_d;
      pmtu_mask  <= mask_d;
    end else if (msg_done && state == roce_pkg::wait_payload) begin
      // psn wraps modulo 2^24
      psn    <= psn + roce_pkg::psn_t'(pkt_count);
      offset <= offset + roce_pkg::vaddr_t'(ctx.length);
    end
  end

  assign hdr_valid   = (state == roce_pkg::issue_hdr);
  assign hdr.psn     = psn;
  assign hdr.dest_qp = ctx.rem_qpn;
  assign hdr.r_key   = ctx.r_key;
  assign hdr.vaddr   = ctx.rem_addr + offset;
  assign hdr.length  = ctx.length;

  assign msg_len = ctx.length;
  assign busy    = (state != roce_pkg::idle);

endmodule

`default_nettype wire

/* logic/roce_pkg.sv */
`default_nettype none

package roce_pkg;

  // beat geometry
  localparam int data_bytes = 8;
  localparam int data_bits = data_bytes * 8;

  // payload buffer entries
  localparam int fifo_depth = 16;

  typedef logic [data_bits-1:0]  beat_data_t;
  typedef logic [data_bytes-1:0] beat_keep_t;

  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;
  typedef logic [31:0] rkey_t;
  typedef logic [63:0] vaddr_t;
  typedef logic [31:0] len_t;
  typedef logic [15:0] msg_count_t;

  // path mtu in bytes, 256 to 4096
  typedef logic [12:0] pmtu_t;
  // log2 of the pmtu and the matching remainder mask
  typedef logic [3:0]  pmtu_shift_t;
  typedef logic [11:0] pmtu_mask_t;

  typedef struct packed {
    len_t       length;
    qpn_t       rem_qpn;
    psn_t       rem_psn;
    rkey_t      r_key;
    vaddr_t     rem_addr;
    msg_count_t n_msgs;
  } xfer_cmd_t;

  // one descriptor per rdma write message
  typedef struct packed {
    psn_t   psn;
    qpn_t   dest_qp;
    rkey_t  r_key;
    vaddr_t vaddr;
    len_t   length;
  } msg_hdr_t;

  typedef struct packed {
    beat_data_t data;
    beat_keep_t keep;
    logic       last;
  } beat_t;

  typedef enum logic [1:0] {
    idle,
    issue_hdr,
    wait_payload
  } tracker_state_t;

endpackage

`default_nettype wire
